// File: dv/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_tb
  import lsu_pkg::*;
  import io_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int N_WORDS = 16;
  localparam int N_SUB   = 48;
  localparam int N_LOADS = 64;
  localparam int N_MIS   = 12;
  localparam int N_IN    = 24;
  localparam int N_NONE  = 12;
  localparam int TOTAL_CYCLES = 10 + 13 + 2 * N_WORDS + N_SUB + N_LOADS + 3 * N_MIS + 3
                                + 36 + N_IN + 7 + 2 * N_NONE + 2;
  localparam int WATCHDOG_NS = (TOTAL_CYCLES + 40) * CLK_PERIOD;

  logic        i_clk = 1'b0;
  logic        i_rst_n;
  logic [15:0] i_addr;
  logic [31:0] i_st_data;
  logic        i_st_en;
  lsu_op_e     i_lsu_op;
  logic [31:0] i_io_sw;
  logic [3:0]  i_io_key;
  logic [31:0] o_ld_data;
  logic        o_misaligned;
  logic [31:0] o_io_ledr;
  logic [31:0] o_io_ledg;
  logic [31:0] o_io_lcd;
  seg7_t       o_io_hex0, o_io_hex1, o_io_hex2, o_io_hex3;
  seg7_t       o_io_hex4, o_io_hex5, o_io_hex6, o_io_hex7;

  // Shadow state of the reference model
  logic [31:0]     sh_mem [`LSU_DMEM_WORDS];
  bit              sh_valid [`LSU_DMEM_WORDS] = '{default: 1'b0};
  logic [31:0]     sh_ledr = '0, sh_ledg = '0, sh_lcd = '0;
  seg7_t [7:0]     sh_hex = '0;
  logic [31:0]     sh_sw_meta = '0, sh_sw_sync = '0;
  logic [3:0]      sh_key_meta = '0, sh_key_sync = '0;
  string           test_name = "reset";
  logic [15:0]     words [$];
  io_reg_e         out_regs [$] = '{IO_LEDR, IO_LEDG, IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3,
                                    IO_HEX4, IO_HEX5, IO_HEX6, IO_HEX7, IO_LCD};
  logic [15:0]     none_bases [$] = '{16'h2000, 16'h4400, 16'h7100, 16'h7900, 16'hc000};

  lsu_top i_lsu_top (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_addr (i_addr), .i_st_data (i_st_data),
    .i_st_en (i_st_en), .i_lsu_op (i_lsu_op), .i_io_sw (i_io_sw), .i_io_key (i_io_key),
    .o_ld_data (o_ld_data), .o_misaligned (o_misaligned), .o_io_ledr (o_io_ledr),
    .o_io_ledg (o_io_ledg), .o_io_hex0 (o_io_hex0), .o_io_hex1 (o_io_hex1),
    .o_io_hex2 (o_io_hex2), .o_io_hex3 (o_io_hex3), .o_io_hex4 (o_io_hex4),
    .o_io_hex5 (o_io_hex5), .o_io_hex6 (o_io_hex6), .o_io_hex7 (o_io_hex7),
    .o_io_lcd (o_io_lcd)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic lsu_region_e region_of(input logic [15:0] a);
    if (a < `LSU_DMEM_LIMIT) return DMEM;
    if (a - `LSU_OUT_BASE < `LSU_REGION_BYTES) return OUTP;  // Wraps below the base
    if (a - `LSU_IN_BASE < `LSU_REGION_BYTES) return INP;
    return NONE;
  endfunction

  function automatic logic ref_misaligned(input logic [15:0] a, input lsu_op_e op);
    if (region_of(a) != DMEM) return 1'b0;
    if (op == LH || op == LHU) return a[0];
    return (op == LW) && (a[1:0] != 2'b00);
  endfunction

  function automatic logic [31:0] ref_word(input logic [15:0] a);
    case (region_of(a))
      DMEM: return sh_mem[a[12:2]];
      OUTP: begin
        case (a[7:0])
          IO_LEDR: return sh_ledr;
          IO_LEDG: return sh_ledg;
          IO_LCD:  return sh_lcd;
          IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3,
          IO_HEX4, IO_HEX5, IO_HEX6, IO_HEX7: return {25'h0, sh_hex[a[2:0]]};
          default: return '0;
        endcase
      end
      INP: begin
        if (a[7:0] == IO_SW) return sh_sw_sync;
        if (a[7:0] == IO_KEY) return {28'h0, sh_key_sync};
        return '0;
      end
      default: return '0;
    endcase
  endfunction

  // Expected load data, lane chosen only inside data memory
  function automatic logic [31:0] ref_load(input logic [15:0] a, input lsu_op_e op);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = ref_word(a);
    b = w[7:0];
    h = w[15:0];
    if (region_of(a) == DMEM) begin
      case (a[1:0])
        2'd1: b = w[15:8];
        2'd2: b = w[23:16];
        2'd3: b = w[31:24];
        default: ;
      endcase
      if (a[1]) h = w[31:16];
    end
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // Store effect on the shadow state, committed at the next rising edge
  task automatic apply_store(input logic [15:0] a, input lsu_op_e op, input logic [31:0] d);
    if (region_of(a) == DMEM && !ref_misaligned(a, op)) begin
      if (op == LB || op == LBU) begin
        case (a[1:0])
          2'd0: sh_mem[a[12:2]][7:0] = d[7:0];
          2'd1: sh_mem[a[12:2]][15:8] = d[7:0];
          2'd2: sh_mem[a[12:2]][23:16] = d[7:0];
          default: sh_mem[a[12:2]][31:24] = d[7:0];
        endcase
      end else if (op == LH || op == LHU) begin
        if (a[1]) sh_mem[a[12:2]][31:16] = d[15:0];
        else sh_mem[a[12:2]][15:0] = d[15:0];
      end else begin
        sh_mem[a[12:2]] = d;
        sh_valid[a[12:2]] = 1'b1;
      end
    end else if (region_of(a) == OUTP) begin
      case (a[7:0])
        IO_LEDR: sh_ledr = d;
        IO_LEDG: sh_ledg = d;
        IO_LCD:  sh_lcd = d;
        IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3,
        IO_HEX4, IO_HEX5, IO_HEX6, IO_HEX7: sh_hex[a[2:0]] = d[6:0];
        default: begin
          sh_ledr = '0;
          sh_ledg = '0;
          sh_lcd  = '0;
          sh_hex  = '0;
        end
      endcase
    end
  endtask

  // Compare mid-cycle, then advance the model for the coming edge
  always @(negedge i_clk) begin
    assert (o_misaligned === ref_misaligned(i_addr, i_lsu_op))
      else fail_run($sformatf("Mismatch in %s: o_misaligned expected %b, actual %b",
                              test_name, ref_misaligned(i_addr, i_lsu_op), o_misaligned));
    if (!ref_misaligned(i_addr, i_lsu_op) &&
        (region_of(i_addr) != DMEM || sh_valid[i_addr[12:2]])) begin
      assert (o_ld_data === ref_load(i_addr, i_lsu_op))
        else fail_run($sformatf("Mismatch in %s: o_ld_data expected %h, actual %h",
                                test_name, ref_load(i_addr, i_lsu_op), o_ld_data));
    end
    assert ({o_io_ledr, o_io_ledg, o_io_lcd} === {sh_ledr, sh_ledg, sh_lcd})
      else fail_run($sformatf("Mismatch in %s: ledr/ledg/lcd expected %h, actual %h",
                              test_name, {sh_ledr, sh_ledg, sh_lcd},
                              {o_io_ledr, o_io_ledg, o_io_lcd}));
    assert ({o_io_hex7, o_io_hex6, o_io_hex5, o_io_hex4, o_io_hex3, o_io_hex2, o_io_hex1,
             o_io_hex0} === sh_hex)
      else fail_run($sformatf("Mismatch in %s: hex7..hex0 expected %h, actual %h",
                              test_name, sh_hex, {o_io_hex7, o_io_hex6, o_io_hex5,
                              o_io_hex4, o_io_hex3, o_io_hex2, o_io_hex1, o_io_hex0}));
    if (i_rst_n) begin
      if (i_st_en) apply_store(i_addr, i_lsu_op, i_st_data);
      sh_sw_sync  = sh_sw_meta;
      sh_sw_meta  = i_io_sw;
      sh_key_sync = sh_key_meta;
      sh_key_meta = i_io_key;
    end
  end

  task automatic access(input logic [15:0] a, input lsu_op_e op, input logic st,
                        input logic [31:0] d);
    @(posedge i_clk);
    i_addr    <= a;
    i_lsu_op  <= op;
    i_st_en   <= st;
    i_st_data <= d;
  endtask

  function automatic lsu_op_e pick_op(input logic [2:0] k);
    case (k)
      3'd0:    return LB;
      3'd1:    return LH;
      3'd2:    return LBU;
      3'd3:    return LHU;
      default: return LW;
    endcase
  endfunction

  function automatic logic [15:0] align_for(input logic [15:0] a, input lsu_op_e op);
    if (op == LH || op == LHU) return {a[15:1], 1'b0};
    if (op == LW) return {a[15:2], 2'b00};
    return a;
  endfunction

  initial begin
    logic [31:0] r;
    logic [15:0] w;
    logic [15:0] a;
    lsu_op_e     op;
    i_rst_n = 1'b0;
    i_addr = `LSU_IN_BASE;
    i_st_data = '0;
    i_st_en = 1'b0;
    i_lsu_op = LW;
    i_io_sw = '0;
    i_io_key = '0;
    void'($urandom(15096));
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
    access(`LSU_IN_BASE + {8'h00, IO_SW}, LW, 1'b0, '0);
    access(`LSU_IN_BASE + {8'h00, IO_KEY}, LW, 1'b0, '0);
    foreach (out_regs[j]) access(`LSU_OUT_BASE + {8'h00, out_regs[j]}, LW, 1'b0, '0);

    test_name = "dmem";
    repeat (N_WORDS) begin
      r = $urandom;
      w = {3'b000, r[12:2], 2'b00};
      words.push_back(w);
      access(w, LW, 1'b1, $urandom);
    end
    // Sub-word and word stores into the seeded words
    repeat (N_SUB) begin
      r = $urandom;
      op = pick_op(r[2:0]);
      a = align_for(words[r[31:8] % words.size()] | {14'b0, r[4:3]}, op);
      access(a, op, 1'b1, $urandom);
    end
    repeat (N_LOADS) begin
      r = $urandom;
      op = pick_op(r[2:0]);
      a = align_for(words[r[31:8] % words.size()] | {14'b0, r[4:3]}, op);
      access(a, op, 1'b0, '0);
    end

    test_name = "misalign";
    repeat (N_MIS) begin
      r = $urandom;
      w = words[r[31:8] % words.size()];
      if (r[0]) begin
        op = r[3] ? LH : LHU;
        a = w | {14'b0, r[1], 1'b1};
      end else begin
        op = LW;
        a = w | {14'b0, (r[2:1] == 2'b00) ? 2'b01 : r[2:1]};
      end
      access(a, op, 1'b1, $urandom);  // Must be dropped
      access(a, op, 1'b0, '0);
      access(w, LW, 1'b0, '0);
    end
    access(`LSU_OUT_BASE + 16'h0021, LH, 1'b0, '0);
    access(`LSU_OUT_BASE + 16'h0002, LW, 1'b0, '0);
    access(`LSU_OUT_BASE + 16'h0013, LW, 1'b0, '0);

    test_name = "output";
    foreach (out_regs[j]) begin
      a = `LSU_OUT_BASE + {8'h00, out_regs[j]};
      access(a, LW, 1'b1, $urandom);
      access(a, LW, 1'b0, '0);
    end
    access(`LSU_OUT_BASE + {8'h00, IO_LEDR}, LB, 1'b0, '0);
    access(`LSU_OUT_BASE + {8'h00, IO_LEDG}, LHU, 1'b0, '0);
    access(`LSU_OUT_BASE + 16'h0044, LW, 1'b1, 32'hffff_ffff);  // Unmapped offset
    foreach (out_regs[j]) access(`LSU_OUT_BASE + {8'h00, out_regs[j]}, LW, 1'b0, '0);

    test_name = "input";
    repeat (N_IN) begin
      r = $urandom;
      access(`LSU_IN_BASE + {8'h00, r[0] ? IO_KEY : IO_SW}, r[1] ? LW : LBU, 1'b0, '0);
      i_io_sw  <= $urandom;
      i_io_key <= r[7:4];
    end
    repeat (4) access(`LSU_IN_BASE + {8'h00, IO_SW}, LW, 1'b1, $urandom);
    access(`LSU_IN_BASE + {8'h00, IO_KEY}, LW, 1'b0, '0);
    access(`LSU_IN_BASE + {8'h00, IO_SW}, LH, 1'b0, '0);
    access(`LSU_IN_BASE + 16'h0004, LW, 1'b0, '0);

    test_name = "unmapped";
    repeat (N_NONE) begin
      r = $urandom;
      a = none_bases[r[2:0] % none_bases.size()] + {8'h00, r[15:8]};
      access(a, pick_op(r[18:16]), 1'b1, $urandom);
      access(a, LW, 1'b0, '0);
    end
    foreach (words[j]) access(words[j], LW, 1'b0, '0);

    access(`LSU_IN_BASE, LW, 1'b0, '0);
    @(posedge i_clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Timeout: the stimulus did not finish in the expected number of cycles");
  end

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_cfg.svh"

module data_mem (
  input  logic       i_clk,
  mem_bus_if.target  bus
);

  localparam int unsigned IDX_W = $clog2(`LSU_DMEM_WORDS);

  logic [31:0]      mem [`LSU_DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = bus.addr[IDX_W+1:2];  // Word index

  always_ff @(posedge i_clk) begin
    if (bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.be[b])
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  assign bus.rdata = mem[idx];  // Asynchronous read

  // A store that touches no byte means the lane logic broke upstream
  a_store_has_lanes : assert property (@(posedge i_clk) bus.we |-> bus.be != 4'b0000)
    else $error("data_mem: store with empty byte enable");

endmodule

`default_nettype wire

// File: hdl/input_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module input_buffer
  import io_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic [31:0] i_io_sw,
  input  logic [3:0]  i_io_key,
  mem_bus_if.target   bus
);

  logic [31:0] sw_meta;
  logic [31:0] sw_sync;
  logic [3:0]  key_meta;
  logic [3:0]  key_sync;

  // Two-stage synchronizer
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      key_meta <= '0;
      key_sync <= '0;
    end else begin
      sw_meta  <= i_io_sw;
      sw_sync  <= sw_meta;
      key_meta <= i_io_key;
      key_sync <= key_meta;
    end
  end

  always_comb begin
    case (bus.addr[7:0])
      IO_SW:   bus.rdata = sw_sync;
      IO_KEY:  bus.rdata = {28'b0, key_sync};
      default: bus.rdata = '0;
    endcase
  end

  // Decoder keeps this region read-only
  a_no_store : assert property (@(posedge i_clk) disable iff (!i_rst_n) !bus.we)
    else $error("input_buffer: store reached the input bank");

endmodule

`default_nettype wire

// File: hdl/io_pkg.sv
`default_nettype none

package io_pkg;

  // Register offset inside a 256-byte peripheral region
  typedef logic [7:0] io_reg_e;

  // Output bank
  localparam io_reg_e IO_LEDR = 8'h00;
  localparam io_reg_e IO_LEDG = 8'h10;
  localparam io_reg_e IO_HEX0 = 8'h20;
  localparam io_reg_e IO_HEX1 = 8'h21;
  localparam io_reg_e IO_HEX2 = 8'h22;
  localparam io_reg_e IO_HEX3 = 8'h23;
  localparam io_reg_e IO_HEX4 = 8'h24;
  localparam io_reg_e IO_HEX5 = 8'h25;
  localparam io_reg_e IO_HEX6 = 8'h26;
  localparam io_reg_e IO_HEX7 = 8'h27;
  localparam io_reg_e IO_LCD  = 8'h30;

  // Input bank
  localparam io_reg_e IO_SW  = 8'h00;
  localparam io_reg_e IO_KEY = 8'h10;

  typedef logic [6:0] seg7_t;  // Seven-segment pattern

endpackage

`default_nettype wire

// File: hdl/lsu_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_decode
  import lsu_pkg::*;
(
  input  logic [15:0]  i_addr,
  input  logic [31:0]  i_st_data,
  input  logic         i_st_en,
  input  lsu_op_e      i_lsu_op,
  output logic [31:0]  o_ld_data,
  output logic         o_misaligned,
  mem_bus_if.initiator dmem,
  mem_bus_if.initiator outp,
  mem_bus_if.initiator inp
);

  lsu_region_e region;
  logic        is_byte;
  logic        is_half;
  logic        is_word;
  logic        is_signed;
  logic [1:0]  lane;
  logic [31:0] rd_word;
  logic [31:0] rd_shift;

  always_comb begin
    is_byte = 1'b0;
    is_half = 1'b0;
    case (i_lsu_op)
      LB, LBU: is_byte = 1'b1;
      LH, LHU: is_half = 1'b1;
      default: ;
    endcase
  end

  assign is_word   = !is_byte && !is_half;
  assign is_signed = (i_lsu_op == LB) || (i_lsu_op == LH);

  always_comb begin
    if (i_addr < `LSU_DMEM_LIMIT)
      region = DMEM;
    else if (i_addr >= `LSU_OUT_BASE && i_addr < `LSU_OUT_BASE + `LSU_REGION_BYTES)
      region = OUTP;
    else if (i_addr >= `LSU_IN_BASE && i_addr < `LSU_IN_BASE + `LSU_REGION_BYTES)
      region = INP;
    else
      region = NONE;
  end

  // Alignment only matters for data memory
  assign o_misaligned = (region == DMEM) &&
                        ((is_half && i_addr[0]) || (is_word && i_addr[1:0] != 2'b00));

  // Store lane placement
  always_comb begin
    dmem.wdata = i_st_data;
    dmem.be    = 4'b1111;
    if (is_byte) begin
      dmem.wdata = {4{i_st_data[7:0]}};
      dmem.be    = 4'b0001 << i_addr[1:0];
    end else if (is_half) begin
      dmem.wdata = {2{i_st_data[15:0]}};
      dmem.be    = i_addr[1] ? 4'b1100 : 4'b0011;
    end
  end

  assign dmem.addr = i_addr;
  assign dmem.we   = i_st_en && (region == DMEM) && !o_misaligned;

  assign outp.addr  = i_addr;
  assign outp.wdata = i_st_data;  // Peripherals take the raw word
  assign outp.be    = 4'b1111;
  assign outp.we    = i_st_en && (region == OUTP);

  // Input region is read-only
  assign inp.addr  = i_addr;
  assign inp.wdata = '0;
  assign inp.be    = '0;
  assign inp.we    = 1'b0;

  always_comb begin
    case (region)
      DMEM:    rd_word = dmem.rdata;
      OUTP:    rd_word = outp.rdata;
      INP:     rd_word = inp.rdata;
      default: rd_word = '0;
    endcase
  end

  // Peripheral registers sit in the low lanes
  assign lane     = (region == DMEM) ? i_addr[1:0] : 2'b00;
  assign rd_shift = rd_word >> {lane, 3'b000};

  always_comb begin
    if (is_byte)
      o_ld_data = {{24{is_signed & rd_shift[7]}}, rd_shift[7:0]};
    else if (is_half)
      o_ld_data = {{16{is_signed & rd_shift[15]}}, rd_shift[15:0]};
    else
      o_ld_data = rd_word;
  end

  // Only one target may commit a store per cycle
  always_comb begin
    assert #0 ($onehot0({dmem.we, outp.we, inp.we}))
      else $error("lsu_decode: several targets strobed at once");
  end

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Access codes follow the RISC-V load funct3 encoding
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd4,
    LHU = 3'd5
  } lsu_op_e;

  // Target selected by the address decoder
  typedef enum logic [1:0] {
    DMEM = 2'd0,
    OUTP = 2'd1,
    INP  = 2'd2,
    NONE = 2'd3   // Nothing mapped here
  } lsu_region_e;

endpackage

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
  import io_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic [15:0] i_addr,
  input  logic [31:0] i_st_data,
  input  logic        i_st_en,
  input  lsu_op_e     i_lsu_op,
  input  logic [31:0] i_io_sw,
  input  logic [3:0]  i_io_key,
  output logic [31:0] o_ld_data,
  output logic        o_misaligned,
  output logic [31:0] o_io_ledr,
  output logic [31:0] o_io_ledg,
  output seg7_t       o_io_hex0,
  output seg7_t       o_io_hex1,
  output seg7_t       o_io_hex2,
  output seg7_t       o_io_hex3,
  output seg7_t       o_io_hex4,
  output seg7_t       o_io_hex5,
  output seg7_t       o_io_hex6,
  output seg7_t       o_io_hex7,
  output logic [31:0] o_io_lcd
);

  mem_bus_if dmem_bus ();
  mem_bus_if out_bus ();
  mem_bus_if in_bus ();

  lsu_decode i_lsu_decode (
    .i_addr       (i_addr),
    .i_st_data    (i_st_data),
    .i_st_en      (i_st_en),
    .i_lsu_op     (i_lsu_op),
    .o_ld_data    (o_ld_data),
    .o_misaligned (o_misaligned),
    .dmem         (dmem_bus.initiator),
    .outp         (out_bus.initiator),
    .inp          (in_bus.initiator)
  );

  data_mem i_data_mem (
    .i_clk (i_clk),
    .bus   (dmem_bus.target)
  );

  output_buffer i_output_buffer (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .bus       (out_bus.target),
    .o_io_ledr (o_io_ledr),
    .o_io_ledg (o_io_ledg),
    .o_io_hex0 (o_io_hex0),
    .o_io_hex1 (o_io_hex1),
    .o_io_hex2 (o_io_hex2),
    .o_io_hex3 (o_io_hex3),
    .o_io_hex4 (o_io_hex4),
    .o_io_hex5 (o_io_hex5),
    .o_io_hex6 (o_io_hex6),
    .o_io_hex7 (o_io_hex7),
    .o_io_lcd  (o_io_lcd)
  );

  input_buffer i_input_buffer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_io_sw  (i_io_sw),
    .i_io_key (i_io_key),
    .bus      (in_bus.target)
  );

endmodule

`default_nettype wire

// File: hdl/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// One access per cycle, no handshake
interface mem_bus_if;

  logic [15:0] addr;   // Byte address
  logic [31:0] wdata;
  logic        we;
  logic [3:0]  be;
  logic [31:0] rdata;  // Combinational from addr

  modport initiator (
    output addr,
    output wdata,
    output we,
    output be,
    input  rdata
  );

  modport target (
    input  addr,
    input  wdata,
    input  we,
    input  be,
    output rdata
  );

endinterface

`default_nettype wire

// File: hdl/output_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module output_buffer
  import io_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  mem_bus_if.target   bus,
  output logic [31:0] o_io_ledr,
  output logic [31:0] o_io_ledg,
  output seg7_t       o_io_hex0,
  output seg7_t       o_io_hex1,
  output seg7_t       o_io_hex2,
  output seg7_t       o_io_hex3,
  output seg7_t       o_io_hex4,
  output seg7_t       o_io_hex5,
  output seg7_t       o_io_hex6,
  output seg7_t       o_io_hex7,
  output logic [31:0] o_io_lcd
);

  logic [31:0] ledr_q;
  logic [31:0] ledg_q;
  logic [31:0] lcd_q;
  seg7_t       hex_q [8];
  io_reg_e     off;

  assign off = bus.addr[7:0];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ledr_q <= '0;
      ledg_q <= '0;
      lcd_q  <= '0;
      hex_q  <= '{default: '0};
    end else if (bus.we) begin
      case (off)
        IO_LEDR: ledr_q <= bus.wdata;
        IO_LEDG: ledg_q <= bus.wdata;
        IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3,
        IO_HEX4, IO_HEX5, IO_HEX6, IO_HEX7:
          hex_q[off[2:0]] <= bus.wdata[6:0];  // Digits keep 7 bits
        IO_LCD:  lcd_q  <= bus.wdata;
        default: begin
          // Unmapped offset wipes the bank
          ledr_q <= '0;
          ledg_q <= '0;
          lcd_q  <= '0;
          hex_q  <= '{default: '0};
        end
      endcase
    end
  end

  // Read back
  always_comb begin
    case (off)
      IO_LEDR: bus.rdata = ledr_q;
      IO_LEDG: bus.rdata = ledg_q;
      IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3,
      IO_HEX4, IO_HEX5, IO_HEX6, IO_HEX7:
        bus.rdata = {25'b0, hex_q[off[2:0]]};
      IO_LCD:  bus.rdata = lcd_q;
      default: bus.rdata = '0;
    endcase
  end

  assign o_io_ledr = ledr_q;
  assign o_io_ledg = ledg_q;
  assign o_io_lcd  = lcd_q;
  assign o_io_hex0 = hex_q[0];
  assign o_io_hex1 = hex_q[1];
  assign o_io_hex2 = hex_q[2];
  assign o_io_hex3 = hex_q[3];
  assign o_io_hex4 = hex_q[4];
  assign o_io_hex5 = hex_q[5];
  assign o_io_hex6 = hex_q[6];
  assign o_io_hex7 = hex_q[7];

endmodule

`default_nettype wire

// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data memory
`define LSU_DMEM_WORDS 2048
`define LSU_DMEM_LIMIT 16'h2000  // First byte address past data memory

// Peripheral regions
`define LSU_OUT_BASE     16'h7000
`define LSU_IN_BASE      16'h7800
`define LSU_REGION_BYTES 16'h0100  // Span of each peripheral region

`endif

// File: project.f
+incdir+include
hdl/lsu_pkg.sv
hdl/io_pkg.sv
hdl/mem_bus_if.sv
hdl/lsu_decode.sv
hdl/data_mem.sv
hdl/output_buffer.sv
hdl/input_buffer.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the load-store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lsu_tb -f project.f -o lsu_sim

# The simulator exits non-zero on $fatal, the log search decides the result
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi
